/* verilog/mem_sys_pkg.sv */
package mem_sys_pkg;

  // ----------------------------------------
  // bus widths
  // ----------------------------------------
  parameter int ADDR_W = 32;             // axi byte address
  parameter int DATA_W = 32;             // one word per beat
  parameter int STRB_W = DATA_W / 8;     // byte lanes

  // ----------------------------------------
  // address map, region is addr[31:28]
  // ----------------------------------------
  parameter logic [3:0] REGION_RAM  = 4'h0;
  parameter logic [3:0] REGION_EXIT = 4'h2;

  typedef logic [25:0] word_addr_t;      // addr[27:2] inside a region

  parameter word_addr_t EXIT_CODE_WORD = word_addr_t'(1);  // byte offset 0x4, latches wdata
  parameter word_addr_t EXIT_ZERO_WORD = word_addr_t'(4);  // byte offset 0x10, latches zero

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } axil_resp_e;

  typedef enum logic [1:0] {
    TGT_RAM,
    TGT_EXIT,
    TGT_NONE                             // unmapped region
  } target_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BRESP,
    ST_RRESP
  } bridge_state_e;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } w_beat_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    axil_resp_e        resp;
  } r_beat_t;

  typedef struct packed {
    logic              en;               // one-cycle strobe, already target qualified
    logic [STRB_W-1:0] we;               // zero on reads
    word_addr_t        word_addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

endpackage

/* verilog/axil_mem_bridge.sv */
module axil_mem_bridge
  import mem_sys_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  // write address / data
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  input  logic [ADDR_W-1:0] aw_addr_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  input  w_beat_t           w_i,
  // write response
  output logic              b_valid_o,
  input  logic              b_ready_i,
  output axil_resp_e        b_resp_o,
  // read address / data
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  logic [ADDR_W-1:0] ar_addr_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output r_beat_t           r_o,
  // memory side
  output mem_req_t          ram_req_o,
  output mem_req_t          exit_req_o,
  input  logic [DATA_W-1:0] ram_rdata_i
);

  bridge_state_e     state_q, state_d;
  target_e           tgt_q, tgt_d;       // target of the open transaction
  axil_resp_e        resp_q, resp_d;
  logic              idle;
  logic              wr_offer;           // aw and w both presented
  logic              wr_hs, rd_hs, hs;
  logic [ADDR_W-1:0] acc_addr;           // address of the accepted beat
  mem_req_t          req;                // shared request fields

  function automatic target_e decode(input logic [3:0] region);
    case (region)
      REGION_RAM:  return TGT_RAM;
      REGION_EXIT: return TGT_EXIT;
      default:     return TGT_NONE;
    endcase
  endfunction

  // ----------------------------------------
  // handshakes
  // ----------------------------------------
  assign idle     = (state_q == ST_IDLE);
  assign wr_offer = aw_valid_i && w_valid_i;

  assign aw_ready_o = idle && wr_offer;     // aw and w accepted together
  assign w_ready_o  = idle && wr_offer;
  assign ar_ready_o = idle && !wr_offer;    // writes win

  assign wr_hs = idle && wr_offer;
  assign rd_hs = ar_ready_o && ar_valid_i;
  assign hs    = wr_hs || rd_hs;

  assign acc_addr = wr_offer ? aw_addr_i : ar_addr_i;
  assign tgt_d    = decode(acc_addr[ADDR_W-1 -: 4]);
  assign resp_d   = (tgt_d == TGT_NONE) ? DECERR : OKAY;

  // ----------------------------------------
  // memory requests, handshake cycle only
  // ----------------------------------------
  always_comb begin
    req           = '0;
    req.word_addr = acc_addr[27:2];         // region bits dropped
    req.wdata     = w_i.data;
    req.we        = wr_hs ? w_i.strb : '0;  // reads carry no strobes

    ram_req_o     = req;
    ram_req_o.en  = hs && (tgt_d == TGT_RAM);
    exit_req_o    = req;
    exit_req_o.en = hs && (tgt_d == TGT_EXIT);
  end

  // ----------------------------------------
  // fsm
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (wr_hs) begin
          state_d = ST_BRESP;
        end else if (rd_hs) begin
          state_d = ST_RRESP;
        end
      end
      ST_BRESP: begin
        if (b_ready_i) begin
          state_d = ST_IDLE;                // b beat taken
        end
      end
      ST_RRESP: begin
        if (r_ready_i) begin
          state_d = ST_IDLE;                // r beat taken
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      tgt_q   <= TGT_NONE;
      resp_q  <= OKAY;
    end else begin
      state_q <= state_d;
      if (hs) begin                         // capture on accept
        tgt_q  <= tgt_d;
        resp_q <= resp_d;
      end
    end
  end

  // ----------------------------------------
  // responses
  // ----------------------------------------
  assign b_valid_o = (state_q == ST_BRESP);
  assign b_resp_o  = resp_q;

  assign r_valid_o = (state_q == ST_RRESP);
  assign r_o.data  = (tgt_q == TGT_RAM) ? ram_rdata_i : '0;  // ram holds its word until next en
  assign r_o.resp  = resp_q;

  // one response channel at a time
  a_one_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(b_valid_o && r_valid_o));

  // decode picks at most one target
  a_one_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ram_req_o.en && exit_req_o.en));

  // read beat held stable under back-pressure, includes ram output
  a_r_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o));

endmodule

/* verilog/word_ram.sv */
module word_ram
  import mem_sys_pkg::*;
#(
  parameter int RAM_ADDR_W = 10          // 2**RAM_ADDR_W words
) (
  input  logic              clk_i,
  input  mem_req_t          req_i,
  output logic [DATA_W-1:0] rdata_o
);

  localparam int DEPTH = 2 ** RAM_ADDR_W;

  logic [DATA_W-1:0]     mem [DEPTH];    // no reset, contents undefined at start
  logic [RAM_ADDR_W-1:0] idx;

  // upper word address bits ignored, so the ram aliases
  assign idx = req_i.word_addr[RAM_ADDR_W-1:0];

  // ----------------------------------------
  // single port, read-before-write
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i.en) begin
      rdata_o <= mem[idx];               // old word, also on writes
      for (int b = 0; b < STRB_W; b++) begin
        if (req_i.we[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];  // strobed lane only
        end
      end
    end
  end

  // an x strobe would corrupt lanes silently
  a_we_known: assert property (@(posedge clk_i)
    req_i.en |-> !$isunknown(req_i.we));

endmodule

/* verilog/exit_reg.sv */
module exit_reg
  import mem_sys_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  mem_req_t          req_i,
  output logic              exit_valid_o,
  output logic [DATA_W-1:0] exit_value_o
);

  logic wr;                              // enabled write, any lane
  logic hit_code;                        // word 1, take wdata
  logic hit_zero;                        // word 4, take zero

  assign wr       = req_i.en && (|req_i.we);
  assign hit_code = wr && (req_i.word_addr == EXIT_CODE_WORD);
  assign hit_zero = wr && (req_i.word_addr == EXIT_ZERO_WORD);

  // ----------------------------------------
  // exit capture
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
    end else begin
      if (hit_code) begin
        exit_valid_o <= 1'b1;
        exit_value_o <= req_i.wdata;
      end else if (hit_zero) begin
        exit_valid_o <= 1'b1;            // clean exit
        exit_value_o <= '0;
      end
      // other exit words are dropped, bridge still answers okay
    end
  end

  // sticky until reset
  a_valid_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exit_valid_o |=> exit_valid_o);

endmodule

/* verilog/mem_sys_top.sv */
module mem_sys_top
  import mem_sys_pkg::*;
#(
  parameter int RAM_ADDR_W = 10          // ram depth in word address bits
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // write address / data
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  input  logic [ADDR_W-1:0] aw_addr_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  input  w_beat_t           w_i,
  // write response
  output logic              b_valid_o,
  input  logic              b_ready_i,
  output axil_resp_e        b_resp_o,
  // read address / data
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  logic [ADDR_W-1:0] ar_addr_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output r_beat_t           r_o,
  // exit report
  output logic              exit_valid_o,
  output logic [DATA_W-1:0] exit_value_o
);

  mem_req_t          ram_req;            // bridge to ram
  mem_req_t          exit_req;           // bridge to exit register
  logic [DATA_W-1:0] ram_rdata;

  // ----------------------------------------
  // axi-lite slave and decode
  // ----------------------------------------
  axil_mem_bridge u_bridge (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .aw_valid_i  (aw_valid_i),
    .aw_ready_o  (aw_ready_o),
    .aw_addr_i   (aw_addr_i),
    .w_valid_i   (w_valid_i),
    .w_ready_o   (w_ready_o),
    .w_i         (w_i),
    .b_valid_o   (b_valid_o),
    .b_ready_i   (b_ready_i),
    .b_resp_o    (b_resp_o),
    .ar_valid_i  (ar_valid_i),
    .ar_ready_o  (ar_ready_o),
    .ar_addr_i   (ar_addr_i),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .r_o         (r_o),
    .ram_req_o   (ram_req),
    .exit_req_o  (exit_req),
    .ram_rdata_i (ram_rdata)
  );

  // ----------------------------------------
  // targets
  // ----------------------------------------
  word_ram #(
    .RAM_ADDR_W (RAM_ADDR_W)
  ) u_ram (
    .clk_i   (clk_i),
    .req_i   (ram_req),
    .rdata_o (ram_rdata)
  );

  exit_reg u_exit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (exit_req),
    .exit_valid_o (exit_valid_o),
    .exit_value_o (exit_value_o)
  );

endmodule

/* bench/tb_mem_sys.sv */
module tb_mem_sys
  import mem_sys_pkg::*;
;

  localparam int TIMEOUT = 50;             // cycles per wait

  logic              clk_i;
  logic              rst_ni;
  logic              aw_valid_i, aw_ready_o;
  logic [ADDR_W-1:0] aw_addr_i;
  logic              w_valid_i, w_ready_o;
  w_beat_t           w_i;
  logic              b_valid_o, b_ready_i;
  axil_resp_e        b_resp_o;
  logic              ar_valid_i, ar_ready_o;
  logic [ADDR_W-1:0] ar_addr_i;
  logic              r_valid_o, r_ready_i;
  r_beat_t           r_o;
  logic              exit_valid_o;
  logic [DATA_W-1:0] exit_value_o;

  int                seed = 57;
  int                checks = 0;
  int                errors = 0;
  int                timeouts = 0;
  bit                aborted = 0;          // set by a timed out wait
  logic              exit_valid_hs;        // exit flag one cycle after a write handshake
  logic [DATA_W-1:0] exit_value_hs;

  mem_sys_top uut (.*);

  always #4 clk_i = ~clk_i;                // period 8

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_r_beat(input string name, input r_beat_t got, input r_beat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_exit(input logic valid, input logic [DATA_W-1:0] value,
                            input logic exp_valid, input logic [DATA_W-1:0] exp_value);
    check_flag("exit_valid_o", valid, exp_valid);
    check_data("exit_value_o", value, exp_value);
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    aborted = 1;
    $display("timeout: no %s within %0d cycles", what, TIMEOUT);
  endtask

  function automatic r_beat_t make_beat(input logic [DATA_W-1:0] data, input axil_resp_e resp);
    r_beat_t beat;
    beat.data = data;
    beat.resp = resp;
    return beat;
  endfunction

  // ----------------------------------------
  // bus driver tasks, drive on falling edge
  // ----------------------------------------
  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  // offer a write on even stall cycles and a read on odd ones
  task automatic offer_during_stall(input int i, input string chan);
    bit wr;
    wr = (i % 2 == 0);
    aw_valid_i = wr;
    w_valid_i  = wr;
    ar_valid_i = !wr;
    @(negedge clk_i);
    if (wr) begin
      check_flag({"aw_ready_o during ", chan, " stall"}, aw_ready_o, 1'b0);
      check_flag({"w_ready_o during ", chan, " stall"}, w_ready_o, 1'b0);
    end else begin
      check_flag({"ar_ready_o during ", chan, " stall"}, ar_ready_o, 1'b0);
    end
  endtask

  task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb, input int hold,
                            output axil_resp_e resp);
    int cnt;
    bit seen;
    resp = OKAY;
    if (aborted) return;
    @(negedge clk_i);
    aw_valid_i = 1'b1;
    aw_addr_i  = addr;
    w_valid_i  = 1'b1;
    w_i.data   = data;
    w_i.strb   = strb;
    cnt  = 0;
    seen = 0;
    while (!seen && cnt < TIMEOUT) begin
      @(posedge clk_i);                    // pre-edge values, dut updates after
      seen = aw_ready_o && w_ready_o;
      cnt++;
    end
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    if (!seen) begin
      report_timeout("write address/data handshake");
      return;
    end
    exit_valid_hs = exit_valid_o;          // one cycle after the handshake edge
    exit_value_hs = exit_value_o;
    cnt = 1;
    while (!b_valid_o && cnt < TIMEOUT) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!b_valid_o) begin
      report_timeout("write response");
      return;
    end
    if (cnt != 1) begin
      errors++;
      $display("b_valid_o rose %0d cycles after the write handshake instead of 1", cnt);
    end
    resp = b_resp_o;
    for (int i = 0; i < hold; i++) begin   // back-pressure on b
      offer_during_stall(i, "b");
      check_flag("b_valid_o held", b_valid_o, 1'b1);
      check_resp("b_resp_o held", b_resp_o, resp);
    end
    aw_valid_i = 1'b0;                     // withdraw the competing offer
    w_valid_i  = 1'b0;
    ar_valid_i = 1'b0;
    b_ready_i  = 1'b1;
    @(negedge clk_i);                      // b taken on the edge between
    b_ready_i = 1'b0;
    check_flag("b_valid_o after b handshake", b_valid_o, 1'b0);
  endtask

  task automatic axil_read(input logic [ADDR_W-1:0] addr, input int hold,
                           output r_beat_t beat);
    int cnt;
    bit seen;
    beat = '0;
    if (aborted) return;
    @(negedge clk_i);
    ar_valid_i = 1'b1;
    ar_addr_i  = addr;
    cnt  = 0;
    seen = 0;
    while (!seen && cnt < TIMEOUT) begin
      @(posedge clk_i);
      seen = ar_ready_o;
      cnt++;
    end
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    if (!seen) begin
      report_timeout("read address handshake");
      return;
    end
    cnt = 1;
    while (!r_valid_o && cnt < TIMEOUT) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!r_valid_o) begin
      report_timeout("read data");
      return;
    end
    if (cnt != 1) begin
      errors++;
      $display("r_valid_o rose %0d cycles after the read handshake instead of 1", cnt);
    end
    beat = r_o;
    for (int i = 0; i < hold; i++) begin   // back-pressure on r
      offer_during_stall(i, "r");
      check_flag("r_valid_o held", r_valid_o, 1'b1);
      check_r_beat("r_o held", r_o, beat);
    end
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    ar_valid_i = 1'b0;
    r_ready_i  = 1'b1;
    @(negedge clk_i);
    r_ready_i = 1'b0;
    check_flag("r_valid_o after r handshake", r_valid_o, 1'b0);
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_reset_state();
    @(negedge clk_i);
    check_flag("aw_ready_o", aw_ready_o, 1'b0);
    check_flag("w_ready_o", w_ready_o, 1'b0);
    check_flag("b_valid_o", b_valid_o, 1'b0);
    check_flag("r_valid_o", r_valid_o, 1'b0);
    check_flag("exit_valid_o", exit_valid_o, 1'b0);
  endtask

  task automatic test_ram_round_trip();
    logic [DATA_W-1:0] words [8];
    axil_resp_e        resp;
    r_beat_t           beat;
    for (int i = 0; i < 8; i++) begin
      words[i] = $random(seed);
      axil_write(32'h100 + 32'(i * 12), words[i], 4'hF, 0, resp);
      check_resp("b_resp_o ram write", resp, OKAY);
    end
    for (int i = 0; i < 8; i++) begin
      axil_read(32'h100 + 32'(i * 12), 0, beat);
      check_r_beat("r_o ram read", beat, make_beat(words[i], OKAY));
    end
  endtask

  task automatic test_byte_strobes();
    logic [DATA_W-1:0] old_w, new_w;
    axil_resp_e        resp;
    r_beat_t           beat;
    old_w = $random(seed);
    new_w = $random(seed);
    axil_write(32'h40, old_w, 4'hF, 0, resp);
    axil_write(32'h40, new_w, 4'h5, 0, resp);   // lanes 0 and 2 only
    check_resp("b_resp_o strobed write", resp, OKAY);
    axil_read(32'h40, 0, beat);
    check_data("r_o.data strobed", beat.data,
               (new_w & 32'h00FF_00FF) | (old_w & 32'hFF00_FF00));
  endtask

  task automatic test_unmapped();
    logic [DATA_W-1:0] keep;
    axil_resp_e        resp;
    r_beat_t           beat;
    keep = $random(seed);
    axil_write(32'h0000_0080, keep, 4'hF, 0, resp);
    axil_write(32'h5000_0080, $random(seed), 4'hF, 0, resp);
    check_resp("b_resp_o unmapped", resp, DECERR);
    axil_read(32'h5000_0080, 0, beat);
    check_r_beat("r_o unmapped", beat, make_beat('0, DECERR));
    axil_read(32'h0000_0080, 0, beat);           // same low address in ram
    check_r_beat("r_o ram after unmapped write", beat, make_beat(keep, OKAY));
  endtask

  task automatic test_backpressure_exit();
    logic [DATA_W-1:0] val;
    axil_resp_e        resp;
    r_beat_t           beat;
    val = $random(seed);
    axil_write(32'h200, val, 4'hF, 5, resp);     // b stalled 5 cycles
    check_resp("b_resp_o stalled write", resp, OKAY);
    axil_read(32'h200, 5, beat);                 // r stalled 5 cycles
    check_r_beat("r_o stalled read", beat, make_beat(val, OKAY));
    axil_read(32'h2000_0004, 0, beat);
    check_r_beat("r_o exit read", beat, make_beat('0, OKAY));
    check_exit(exit_valid_o, exit_value_o, 1'b0, '0);
    val = $random(seed);
    axil_write(32'h2000_0004, val, 4'hF, 0, resp);
    check_resp("b_resp_o exit code", resp, OKAY);
    check_exit(exit_valid_hs, exit_value_hs, 1'b1, val);
    axil_write(32'h2000_0010, $random(seed), 4'hF, 0, resp);
    check_exit(exit_valid_hs, exit_value_hs, 1'b1, '0);
    wait_cycles(2);
    check_exit(exit_valid_o, exit_value_o, 1'b1, '0);   // still sticky
  endtask

  initial begin
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    w_valid_i  = 1'b0;
    w_i        = '0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    b_ready_i  = 1'b0;
    r_ready_i  = 1'b0;
    wait_cycles(10);                       // reset for 10 cycles
    rst_ni = 1'b1;
    test_reset_state();
    test_ram_round_trip();
    test_byte_strobes();
    test_unmapped();
    test_backpressure_exit();
    wait_cycles(2);
    $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
verilog/mem_sys_pkg.sv
verilog/axil_mem_bridge.sv
verilog/word_ram.sv
verilog/exit_reg.sv
verilog/mem_sys_top.sv
bench/tb_mem_sys.sv

/* Makefile */
TOP := tb_mem_sys

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)
	verilator --lint-only --assert -f vlog.f --top-module mem_sys_top

obj_dir/sim_tb: vlog.f verilog/*.sv bench/*.sv
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) \
		--Mdir obj_dir -o sim_tb

sim: obj_dir/sim_tb
	out="$$(./obj_dir/sim_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
